/* include/permSum_params.svh */
`ifndef PERMSUM_PARAMS_SVH
`define PERMSUM_PARAMS_SVH

// function shape
`define NUM_VARS 5
`define FUNC_BITS 32
`define NUM_LANES 5

// result widths
`define LANE_SUM_BITS 6
`define SUM_BITS 24
`define COUNT_BITS 16

// host port
`define WB_ADDR_BITS 3
`define INFLIGHT_BITS 3

`endif

/* design/funcPkg.sv */
`include "permSum_params.svh"

package funcPkg;

    // truth table, bit i holds f(i)
    typedef logic [`FUNC_BITS-1:0] funcT;

    // popcount of top and not bot, one lane
    typedef logic [`LANE_SUM_BITS-1:0] laneSumT;

    // running totals
    typedef logic [`SUM_BITS-1:0] sumT;
    typedef logic [`COUNT_BITS-1:0] countT;

endpackage

/* design/busPkg.sv */
`include "permSum_params.svh"

package busPkg;

    // word addresses of the register map
    typedef enum logic [`WB_ADDR_BITS-1:0] {
        ADDR_TOP   = 0,
        ADDR_BOT   = 1,
        ADDR_SUM   = 2,
        ADDR_COUNT = 3,
        ADDR_CTRL  = 4
    } regAddrE;

    // words accepted by the control register
    typedef enum logic [31:0] {
        CMD_NONE  = 32'h0000_0000,
        CMD_CLEAR = 32'h0000_0001
    } cmdE;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_ACK
    } portStateE;

endpackage

/* design/wbHostPort.sv */
`timescale 1ns/1ps

`include "permSum_params.svh"

module wbHostPort (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [`WB_ADDR_BITS-1:0] adr,
    input  logic [31:0]              datIn,
    output logic [31:0]              datOut,
    output logic                     ack,
    output funcPkg::funcT            top,
    output funcPkg::funcT            bot,
    output logic                     launch,
    output logic                     clear,
    input  logic                     accumDone,
    input  funcPkg::sumT             sumTotal,
    input  funcPkg::countT           countTotal
);

    import funcPkg::*;
    import busPkg::*;

    localparam logic [`INFLIGHT_BITS-1:0] FLIGHT_ONE = 1;

    portStateE                 state;
    regAddrE                   addr;
    cmdE                       cmd;
    logic                      resultAccess;
    logic                      botWrite;
    logic [31:0]               readData;
    logic [`INFLIGHT_BITS-1:0] inFlight;

    assign addr = regAddrE'(adr);
    assign cmd  = cmdE'(datIn);

    // these must see every launched item reach the totals
    assign resultAccess = we ? (addr == ADDR_CTRL && cmd == CMD_CLEAR)
                             : (addr == ADDR_SUM || addr == ADDR_COUNT);

    assign botWrite = (state == ST_IDLE) && cyc && stb && we && (addr == ADDR_BOT);
    assign ack = (state == ST_ACK);

    always_comb begin
        case (addr)
            ADDR_TOP:   readData = top;
            ADDR_SUM:   readData = 32'(sumTotal);
            ADDR_COUNT: readData = 32'(countTotal);
            default:    readData = '0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ST_IDLE;
            launch <= 1'b0;
            clear  <= 1'b0;
            top    <= '0;
        end else begin
            launch <= 1'b0;
            clear  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cyc && stb) begin
                        if (resultAccess) begin
                            state <= ST_WAIT;
                        end else begin
                            state <= ST_ACK;
                            if (we && addr == ADDR_TOP) begin
                                top <= funcT'(datIn);
                            end
                            launch <= botWrite;
                        end
                    end
                end
                ST_WAIT: begin
                    // only the clear command waits with we set
                    if (inFlight == '0) begin
                        state <= ST_ACK;
                        clear <= we;
                    end
                end
                ST_ACK: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (botWrite) begin
            bot <= funcT'(datIn);
        end
        // hold read data steady through ack
        if (state != ST_ACK) begin
            datOut <= readData;
        end
    end

    // items between launch and the totals
    always_ff @(posedge clk) begin
        if (reset) begin
            inFlight <= '0;
        end else begin
            case ({launch, accumDone})
                2'b10:   inFlight <= inFlight + FLIGHT_ONE;
                2'b01:   inFlight <= inFlight - FLIGHT_ONE;
                default: inFlight <= inFlight;
            endcase
        end
    end

    ackInCycle: assert property (@(posedge clk) disable iff (reset)
        ack |-> (cyc && stb))
        else $error("ack raised outside an active bus cycle");

    noUnderflow: assert property (@(posedge clk) disable iff (reset)
        accumDone |-> (inFlight != '0))
        else $error("result arrived with nothing in flight");

endmodule

/* design/permLane.sv */
`timescale 1ns/1ps

`include "permSum_params.svh"

module permLane #(
    parameter int swapVar = 0
) (
    input  logic              clk,
    input  logic              reset,
    input  funcPkg::funcT     top,
    input  funcPkg::funcT     bot,
    input  logic              launch,
    output logic              hit,
    output funcPkg::laneSumT  bitCount,
    output logic              done
);

    import funcPkg::*;

    funcT permuted;
    funcT permReg;
    funcT topReg;
    logic stageValid;
    logic subset;

    // table index with variable 0 and swapVar exchanged
    function automatic logic [`NUM_VARS-1:0] swapIndex(input logic [`NUM_VARS-1:0] idx);
        logic [`NUM_VARS-1:0] result;
        result = idx;
        result[0] = idx[swapVar];
        result[swapVar] = idx[0];
        return result;
    endfunction

    function automatic laneSumT countBits(input funcT value);
        laneSumT total;
        total = '0;
        for (int i = 0; i < `FUNC_BITS; i++) begin
            total = total + laneSumT'(value[i]);
        end
        return total;
    endfunction

    always_comb begin
        for (int i = 0; i < `FUNC_BITS; i++) begin
            permuted[i] = bot[swapIndex(i[`NUM_VARS-1:0])];
        end
    end

    // no bit of the permuted bot outside top
    assign subset = ((permReg & ~topReg) == '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            stageValid <= 1'b0;
            done       <= 1'b0;
        end else begin
            stageValid <= launch;
            done       <= stageValid;
        end
    end

    // stage one
    always_ff @(posedge clk) begin
        if (launch) begin
            permReg <= permuted;
            topReg  <= top;
        end
    end

    // stage two, misses contribute nothing
    always_ff @(posedge clk) begin
        if (stageValid) begin
            hit      <= subset;
            bitCount <= subset ? countBits(topReg & ~permReg) : '0;
        end
    end

    missIsEmpty: assert property (@(posedge clk) disable iff (reset)
        (done && !hit) |-> (bitCount == '0))
        else $error("lane %0d reports bits on a miss", swapVar);

endmodule

/* design/laneReducer.sv */
`timescale 1ns/1ps

`include "permSum_params.svh"

module laneReducer (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic [`NUM_LANES-1:0]                  hit,
    input  funcPkg::laneSumT [`NUM_LANES-1:0]      bitCount,
    input  logic [`NUM_LANES-1:0]                  done,
    input  logic                                   clear,
    output funcPkg::sumT                           sumTotal,
    output funcPkg::countT                         countTotal,
    output logic                                   accumDone
);

    import funcPkg::*;

    // room for every lane at full count
    localparam int TREE_BITS = `LANE_SUM_BITS + $clog2(`NUM_LANES);
    localparam int HIT_BITS  = $clog2(`NUM_LANES + 1);
    localparam logic [HIT_BITS-1:0] HIT_ONE = 1;

    logic [TREE_BITS-1:0] laneSum;
    logic [HIT_BITS-1:0]  laneHits;
    logic [TREE_BITS-1:0] stageSum;
    logic [HIT_BITS-1:0]  stageHits;
    logic                 stageValid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage one, sum across lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        laneSum  = '0;
        laneHits = '0;
        for (int k = 0; k < `NUM_LANES; k++) begin
            if (hit[k] && done[k]) begin
                laneSum  = laneSum + TREE_BITS'(bitCount[k]);
                laneHits = laneHits + HIT_ONE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stageValid <= 1'b0;
        end else begin
            stageValid <= done[0];
        end
    end

    always_ff @(posedge clk) begin
        stageSum  <= laneSum;
        stageHits <= laneHits;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage two, running totals
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            sumTotal   <= '0;
            countTotal <= '0;
            accumDone  <= 1'b0;
        end else begin
            accumDone <= stageValid;
            // clear wins, nothing is pending when it comes
            if (clear) begin
                sumTotal   <= '0;
                countTotal <= '0;
            end else if (stageValid) begin
                sumTotal   <= sumTotal + sumT'(stageSum);
                countTotal <= countTotal + countT'(stageHits);
            end
        end
    end

    lanesInStep: assert property (@(posedge clk) disable iff (reset)
        (done == '0) || (&done))
        else $error("lanes finished out of step");

endmodule

/* design/permSumTop.sv */
`timescale 1ns/1ps

`include "permSum_params.svh"

module permSumTop (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     cyc,
    input  logic                     stb,
    input  logic                     we,
    input  logic [`WB_ADDR_BITS-1:0] adr,
    input  logic [31:0]              datIn,
    output logic [31:0]              datOut,
    output logic                     ack
);

    import funcPkg::*;

    funcT                       top;
    funcT                       bot;
    logic                       launch;
    logic                       clear;
    logic [`NUM_LANES-1:0]      laneHit;
    laneSumT [`NUM_LANES-1:0]   laneBitCount;
    logic [`NUM_LANES-1:0]      laneDone;
    sumT                        sumTotal;
    countT                      countTotal;
    logic                       accumDone;

    wbHostPort hostPort (
        .clk        (clk),
        .reset      (reset),
        .cyc        (cyc),
        .stb        (stb),
        .we         (we),
        .adr        (adr),
        .datIn      (datIn),
        .datOut     (datOut),
        .ack        (ack),
        .top        (top),
        .bot        (bot),
        .launch     (launch),
        .clear      (clear),
        .accumDone  (accumDone),
        .sumTotal   (sumTotal),
        .countTotal (countTotal)
    );

    // lane k swaps variable 0 with variable k
    for (genvar k = 0; k < `NUM_LANES; k++) begin : gLane
        permLane #(
            .swapVar (k)
        ) lane (
            .clk      (clk),
            .reset    (reset),
            .top      (top),
            .bot      (bot),
            .launch   (launch),
            .hit      (laneHit[k]),
            .bitCount (laneBitCount[k]),
            .done     (laneDone[k])
        );
    end

    laneReducer reducer (
        .clk        (clk),
        .reset      (reset),
        .hit        (laneHit),
        .bitCount   (laneBitCount),
        .done       (laneDone),
        .clear      (clear),
        .sumTotal   (sumTotal),
        .countTotal (countTotal),
        .accumDone  (accumDone)
    );

endmodule

/* bench/wbHostTasks.svh */
`ifndef WB_HOST_TASKS_SVH
`define WB_HOST_TASKS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic master side
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// called 2 ns after a rising edge, returns at the same point
task automatic busAccess(input logic write, input regAddrE addr, input logic [31:0] data,
                         output logic [31:0] rdata);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    rdata  = '0;
    cyc    = 1'b1;
    stb    = 1'b1;
    we     = write;
    adr    = addr;
    datIn  = data;
    while (!seen && waited < ACK_TIMEOUT) begin
        @(posedge clk);
        #2;
        waited++;
        seen = ack;
    end
    if (seen) begin
        rdata = datOut;
        // stb stays up through the edge that samples ack
        @(posedge clk);
        #2;
    end else begin
        $display("no ack from address %0d after %0d cycles at time %0t",
                 addr, ACK_TIMEOUT, $time);
        timeouts++;
    end
    cyc = 1'b0;
    stb = 1'b0;
    we  = 1'b0;
endtask

task automatic busWrite(input regAddrE addr, input logic [31:0] data);
    logic [31:0] unused;
    busAccess(1'b1, addr, data, unused);
endtask

task automatic busRead(input regAddrE addr, output logic [31:0] data);
    busAccess(1'b0, addr, '0, data);
endtask

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// f with variables 0 and k exchanged
function automatic funcT permuteVars(input funcT f, input int k);
    funcT p;
    int   j;
    int   b0;
    int   bk;
    for (int i = 0; i < `FUNC_BITS; i++) begin
        b0 = i & 1;
        bk = (i >> k) & 1;
        j = (i & ~(1 | (1 << k))) | bk | (b0 << k);
        p[i] = f[j];
    end
    return p;
endfunction

function automatic sumT modelSum(input funcT t, input funcT b);
    sumT  total;
    funcT p;
    total = '0;
    for (int k = 0; k < `NUM_LANES; k++) begin
        p = permuteVars(b, k);
        if ((p & ~t) == '0) begin
            total = total + sumT'($countones(t & ~p));
        end
    end
    return total;
endfunction

function automatic countT modelHits(input funcT t, input funcT b);
    countT hits;
    hits = '0;
    for (int k = 0; k < `NUM_LANES; k++) begin
        if ((permuteVars(b, k) & ~t) == '0) begin
            hits = hits + countT'(1);
        end
    end
    return hits;
endfunction

`endif

/* bench/permSumTb.sv */
`timescale 1ns/1ps

`include "permSum_params.svh"

module permSumTb;

    import funcPkg::*;
    import busPkg::*;

    localparam int ACK_TIMEOUT = 16;
    localparam int RANDOM_BOTS = 20;

    typedef enum logic {
        OP_WRITE,
        OP_READ
    } opE;

    typedef struct packed {
        opE          op;
        regAddrE     addr;
        logic [31:0] data;
        logic [31:0] expected;
    } stepT;

    logic                     clk;
    logic                     reset;
    logic                     cyc;
    logic                     stb;
    logic                     we;
    logic [`WB_ADDR_BITS-1:0] adr;
    logic [31:0]              datIn;
    logic [31:0]              datOut;
    logic                     ack;

    int     mismatches = 0;
    int     timeouts = 0;
    integer seed = 35341;
    funcT   modelTop = '0;
    sumT    expSum = '0;
    countT  expCount = '0;
    stepT   steps[$];

    `include "wbHostTasks.svh"

    permSumTop dut_i (
        .clk    (clk),
        .reset  (reset),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .datIn  (datIn),
        .datOut (datOut),
        .ack    (ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic checkTop(input funcT got, input funcT want, input string what);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, want);
            mismatches++;
        end
    endtask

    task automatic checkSum(input sumT got, input sumT want, input string what);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, want);
            mismatches++;
        end
    endtask

    task automatic checkCount(input countT got, input countT want, input string what);
        if (got !== want) begin
            $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, want);
            mismatches++;
        end
    endtask

    task automatic addStep(input opE op, input regAddrE addr, input logic [31:0] data,
                           input logic [31:0] expected);
        stepT s;
        s.op       = op;
        s.addr     = addr;
        s.data     = data;
        s.expected = expected;
        steps.push_back(s);
    endtask

    task automatic addBotToModel(input funcT b);
        sumT   s;
        countT c;
        // full top makes every lane hit and a swap keeps the popcount
        if (modelTop == '1) begin
            s = sumT'(`NUM_LANES * (`FUNC_BITS - $countones(b)));
            c = countT'(`NUM_LANES);
        end else begin
            s = modelSum(modelTop, b);
            c = modelHits(modelTop, b);
        end
        expSum   = expSum + s;
        expCount = expCount + c;
    endtask

    task automatic applyStep(input stepT s);
        logic [31:0] rdata;
        if (s.op == OP_WRITE) begin
            busWrite(s.addr, s.data);
            case (s.addr)
                ADDR_TOP: modelTop = funcT'(s.data);
                ADDR_BOT: addBotToModel(funcT'(s.data));
                ADDR_CTRL: begin
                    if (cmdE'(s.data) == CMD_CLEAR) begin
                        expSum   = '0;
                        expCount = '0;
                    end
                end
                default: ;
            endcase
        end else begin
            busRead(s.addr, rdata);
            case (s.addr)
                ADDR_SUM:   checkSum(sumT'(rdata), expSum, "sum total");
                ADDR_COUNT: checkCount(countT'(rdata), expCount, "hit count");
                default:    checkTop(funcT'(rdata), funcT'(s.expected), "register readback");
            endcase
        end
    endtask

    task automatic loadSteps();
        // values after reset
        addStep(OP_READ, ADDR_TOP, 32'h0, 32'h0);
        addStep(OP_READ, ADDR_SUM, 32'h0, 32'h0);
        addStep(OP_READ, ADDR_COUNT, 32'h0, 32'h0);
        addStep(OP_WRITE, ADDR_TOP, 32'hA5C3_0F96, 32'h0);
        addStep(OP_READ, ADDR_TOP, 32'h0, 32'hA5C3_0F96);
        // full top where every permutation hits
        addStep(OP_WRITE, ADDR_TOP, 32'hFFFF_FFFF, 32'h0);
        addStep(OP_WRITE, ADDR_BOT, 32'h0000_0001, 32'h0);
        addStep(OP_WRITE, ADDR_BOT, 32'h1234_5678, 32'h0);
        addStep(OP_WRITE, ADDR_BOT, 32'hFFFF_FFFF, 32'h0);
        addStep(OP_WRITE, ADDR_BOT, 32'h0000_0000, 32'h0);
        addStep(OP_READ, ADDR_SUM, 32'h0, 32'h0);
        addStep(OP_READ, ADDR_COUNT, 32'h0, 32'h0);
        // mixed top where lanes disagree
        addStep(OP_WRITE, ADDR_TOP, 32'h0F0F_00FF, 32'h0);
        addStep(OP_WRITE, ADDR_BOT, 32'h0000_0003, 32'h0);
        addStep(OP_WRITE, ADDR_BOT, 32'h0000_0101, 32'h0);
        addStep(OP_WRITE, ADDR_BOT, 32'h0003_0000, 32'h0);
        addStep(OP_WRITE, ADDR_BOT, 32'h0000_00F0, 32'h0);
        addStep(OP_READ, ADDR_SUM, 32'h0, 32'h0);
        addStep(OP_READ, ADDR_COUNT, 32'h0, 32'h0);
        // back to back bots and a read that must wait
        addStep(OP_WRITE, ADDR_TOP, 32'hFFFF_FFFD, 32'h0);
        addStep(OP_WRITE, ADDR_BOT, 32'h0000_0002, 32'h0);
        addStep(OP_WRITE, ADDR_BOT, 32'h0000_0010, 32'h0);
        addStep(OP_WRITE, ADDR_BOT, 32'h0001_0004, 32'h0);
        addStep(OP_READ, ADDR_SUM, 32'h0, 32'h0);
        addStep(OP_READ, ADDR_COUNT, 32'h0, 32'h0);
        // no-op command leaves totals alone and clear zeroes them
        addStep(OP_WRITE, ADDR_CTRL, CMD_NONE, 32'h0);
        addStep(OP_READ, ADDR_COUNT, 32'h0, 32'h0);
        addStep(OP_WRITE, ADDR_CTRL, CMD_CLEAR, 32'h0);
        addStep(OP_READ, ADDR_SUM, 32'h0, 32'h0);
        addStep(OP_READ, ADDR_COUNT, 32'h0, 32'h0);
    endtask

    initial begin
        logic [31:0] rdata;
        funcT        randBot;
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        datIn = '0;
        loadSteps();
        repeat (2) @(posedge clk);
        #2;
        reset = 1'b0;

        foreach (steps[i]) begin
            applyStep(steps[i]);
        end

        // random bots from cleared totals
        for (int n = 0; n < RANDOM_BOTS; n++) begin
            randBot = funcT'($random(seed));
            busWrite(ADDR_BOT, randBot);
            addBotToModel(randBot);
        end
        busRead(ADDR_SUM, rdata);
        checkSum(sumT'(rdata), expSum, "sum after random bots");
        busRead(ADDR_COUNT, rdata);
        checkCount(countT'(rdata), expCount, "count after random bots");

        $display("error counts: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
+incdir+bench
design/funcPkg.sv
design/busPkg.sv
design/wbHostPort.sv
design/permLane.sv
design/laneReducer.sv
design/permSumTop.sv
bench/permSumTb.sv

/* run.sh */
#!/bin/sh
# build the permutation-sum testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

TOP=permSumTb
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module "$TOP" -f all.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
    echo "testbench reported failures, see $LOG"
    exit 1
fi

exit 0
